/* hdl/farm_pkg.sv */
package farm_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int DATA_W  = 8;     // Reading, pixel and status byte width
    localparam int STAGE_W = 3;     // Growth stage field

    // ========================================
    // Control encodings
    // ========================================
    typedef enum logic [1:0] {
        CH_SOIL  = 2'd0,
        CH_TEMP  = 2'd1,
        CH_HUMID = 2'd2,
        CH_LIGHT = 2'd3
    } sensor_chan_e;

    typedef enum logic {
        MODE_SENSOR = 1'b0,
        MODE_CAMERA = 1'b1          // uio_in[7] high
    } op_mode_e;

    // Maturity grades as shown on uio_out in camera mode
    typedef enum logic [DATA_W-1:0] {
        MAT_0  = 8'd0,              // Too few green pixels
        MAT_20 = 8'd20,             // Light green dominates
        MAT_40 = 8'd40,
        MAT_70 = 8'd70,
        MAT_90 = 8'd90              // Deep green dominates
    } maturity_e;

    // ========================================
    // Sensor windows
    // ========================================
    typedef struct packed {
        logic [DATA_W-1:0] min_val;
        logic [DATA_W-1:0] max_val;
    } limit_t;

    // Entry order follows sensor_chan_e
    localparam limit_t SENSOR_LIMITS [4] = '{
        '{min_val: 8'd140, max_val: 8'd210},    // Soil moisture
        '{min_val: 8'd100, max_val: 8'd160},    // Temperature
        '{min_val: 8'd120, max_val: 8'd190},    // Humidity
        '{min_val: 8'd80,  max_val: 8'd220}     // Light
    };

    // ========================================
    // Result bundles
    // ========================================
    typedef struct packed {
        logic [3:0]        alert_code;  // One bit per channel, average out of window
        logic [3:0]        fault_code;  // Stuck or extreme, per channel
        logic [DATA_W-1:0] avg_sel;     // Average of selected channel
    } sensor_result_t;

    typedef struct packed {
        logic               ready;      // Harvest ready
        logic [STAGE_W-1:0] stage;
        maturity_e          maturity;
    } growth_result_t;

endpackage

/* hdl/sensor_monitor.sv */
`timescale 1ns/1ps

module sensor_monitor import farm_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ena,
    input  op_mode_e          mode,
    input  sensor_chan_e      chan,
    input  logic [DATA_W-1:0] reading,
    output sensor_result_t    result
);

    localparam int NUM_CH = 4;
    localparam int DEPTH  = 4;          // Samples per running average
    localparam int SUM_W  = DATA_W + 2; // Holds four full-scale samples

    // Captured sample
    logic              smp_vld;
    sensor_chan_e      smp_chan;
    logic [DATA_W-1:0] smp_data;

    // Per-channel averaging and stuck tracking
    logic [DATA_W-1:0] history [NUM_CH][DEPTH];
    logic [1:0]        wr_idx  [NUM_CH];    // Own write pointer per channel
    logic [SUM_W-1:0]  run_sum [NUM_CH];
    logic [DATA_W-1:0] avg     [NUM_CH];
    logic [DATA_W-1:0] last_rd [NUM_CH];
    logic [NUM_CH-1:0] stuck;

    logic [SUM_W-1:0]  sum_next;
    logic [NUM_CH-1:0] alert_d;
    logic [NUM_CH-1:0] extreme_d;

    // ========================================
    // Stage 0, capture reading
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            smp_vld  <= 1'b0;
            smp_chan <= CH_SOIL;
            smp_data <= '0;
        end else if (ena) begin
            smp_vld  <= (mode == MODE_SENSOR);  // Camera cycles carry no reading
            smp_chan <= chan;
            smp_data <= reading;
        end
    end

    // Drop oldest sample, add newest
    assign sum_next = run_sum[smp_chan]
                    - SUM_W'(history[smp_chan][wr_idx[smp_chan]])
                    + SUM_W'(smp_data);

    // ========================================
    // Stage 1, history and average
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < NUM_CH; c++) begin
                for (int k = 0; k < DEPTH; k++) begin
                    history[c][k] <= '0;
                end
                wr_idx[c]  <= '0;
                run_sum[c] <= '0;
                avg[c]     <= '0;
                last_rd[c] <= '0;
            end
            stuck <= '0;
        end else if (ena && smp_vld) begin
            history[smp_chan][wr_idx[smp_chan]] <= smp_data;
            wr_idx[smp_chan]  <= wr_idx[smp_chan] + 2'd1;   // Wraps at four
            run_sum[smp_chan] <= sum_next;
            avg[smp_chan]     <= sum_next[SUM_W-1:2];       // Divide by four

            // Same value twice in a row on this channel
            if (smp_data == last_rd[smp_chan]) begin
                stuck[smp_chan] <= 1'b1;
            end else begin
                stuck[smp_chan]   <= 1'b0;
                last_rd[smp_chan] <= smp_data;
            end
        end
    end

    // Window and extreme checks on registered averages
    always_comb begin
        for (int c = 0; c < NUM_CH; c++) begin
            alert_d[c]   = (avg[c] < SENSOR_LIMITS[c].min_val) ||
                           (avg[c] > SENSOR_LIMITS[c].max_val);
            extreme_d[c] = (avg[c] == '0) || (avg[c] == '1);  // Rail codes 0 and 255
        end
    end

    // ========================================
    // Stage 2, alert and fault codes
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else if (ena) begin
            result.alert_code <= alert_d;
            result.fault_code <= stuck | extreme_d;
            result.avg_sel    <= avg[chan];     // Follows live channel select
        end
    end

endmodule

/* hdl/growth_classifier.sv */
`timescale 1ns/1ps

module growth_classifier import farm_pkg::*; #(
    parameter int COUNT_W          = 12,
    parameter int MIN_FRAME_PIXELS = 100,
    parameter int MIN_GREEN_PIXELS = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ena,
    input  logic              vsync,
    input  logic              href,
    input  op_mode_e          mode,
    input  logic [DATA_W-1:0] pixel,
    output growth_result_t    result
);

    localparam logic [2:0] RED_LIMIT   = 3'd2;  // Red field must stay below
    localparam logic [2:0] LIGHT_G_MIN = 3'd3;
    localparam logic [2:0] LIGHT_G_MAX = 3'd5;  // Above this is deep green

    // RGB332 fields
    logic [2:0] red_f;
    logic [2:0] green_f;
    logic       is_light;
    logic       is_deep;

    // Frame counters
    logic [COUNT_W-1:0] light_cnt;
    logic [COUNT_W-1:0] deep_cnt;
    logic [COUNT_W-1:0] total_cnt;

    logic [COUNT_W:0]   green_sum;      // One extra bit, no wrap
    logic [COUNT_W:0]   light_x2;
    logic [COUNT_W:0]   deep_x2;
    logic               frame_done;
    maturity_e          mat_next;

    // Evaluation state
    maturity_e          maturity_q;
    logic [STAGE_W-1:0] stage_q;
    logic               ready_q;
    logic               eval_pend;      // Maturity fresh, stage due next edge

    assign red_f    = pixel[7:5];
    assign green_f  = pixel[4:2];
    assign is_light = (green_f >= LIGHT_G_MIN) && (green_f <= LIGHT_G_MAX) &&
                      (red_f < RED_LIMIT);
    assign is_deep  = (green_f > LIGHT_G_MAX) && (red_f < RED_LIMIT);

    assign green_sum  = {1'b0, light_cnt} + {1'b0, deep_cnt};
    assign light_x2   = {light_cnt, 1'b0};
    assign deep_x2    = {deep_cnt, 1'b0};
    assign frame_done = !vsync && !href && (total_cnt > COUNT_W'(MIN_FRAME_PIXELS));

    // Ratio grading, no divider
    always_comb begin
        if (green_sum <= (COUNT_W+1)'(MIN_GREEN_PIXELS)) begin
            mat_next = MAT_0;
        end else if ({1'b0, deep_cnt} > light_x2) begin
            mat_next = MAT_90;
        end else if (deep_cnt > light_cnt) begin
            mat_next = MAT_70;
        end else if ({1'b0, light_cnt} > deep_x2) begin
            mat_next = MAT_20;
        end else begin
            mat_next = MAT_40;
        end
    end

    // ========================================
    // Pixel counting and maturity
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            light_cnt  <= '0;
            deep_cnt   <= '0;
            total_cnt  <= '0;
            maturity_q <= MAT_0;
            eval_pend  <= 1'b0;
        end else if (ena) begin
            eval_pend <= 1'b0;
            if (mode == MODE_CAMERA) begin
                if (vsync) begin            // New frame
                    light_cnt <= '0;
                    deep_cnt  <= '0;
                    total_cnt <= '0;
                end else if (href) begin
                    total_cnt <= total_cnt + 1'b1;
                    if (is_light) light_cnt <= light_cnt + 1'b1;
                    if (is_deep)  deep_cnt  <= deep_cnt + 1'b1;
                end else if (frame_done) begin
                    maturity_q <= mat_next;
                    eval_pend  <= 1'b1;
                end
            end
        end
    end

    // Stage from this evaluation's maturity
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_q <= '0;
            ready_q <= 1'b0;
        end else if (ena && eval_pend) begin
            ready_q <= (maturity_q >= 8'd60);   // Stages 6 and 7
            if      (maturity_q >= 8'd80) stage_q <= 3'd7;
            else if (maturity_q >= 8'd60) stage_q <= 3'd6;
            else if (maturity_q >= 8'd40) stage_q <= 3'd4;
            else if (maturity_q >= 8'd20) stage_q <= 3'd2;
            else                          stage_q <= 3'd1;  // Germination
        end
    end

    assign result = '{ready: ready_q, stage: stage_q, maturity: maturity_q};

endmodule

/* hdl/status_combiner.sv */
`timescale 1ns/1ps

module status_combiner import farm_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ena,
    input  op_mode_e          mode,
    input  sensor_chan_e      chan,
    input  sensor_result_t    sensor,
    input  growth_result_t    growth,
    output logic [DATA_W-1:0] uo_out,
    output logic [DATA_W-1:0] uio_out
);

    logic       buzzer;
    logic [3:0] alert_hold;     // Last sensor-mode alert code

    // Any alert or fault sounds the buzzer
    assign buzzer = |{sensor.alert_code, sensor.fault_code};

    // ========================================
    // Pin registers
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uo_out     <= '0;
            uio_out    <= '0;
            alert_hold <= '0;
        end else if (ena) begin
            if (mode == MODE_SENSOR) begin
                alert_hold <= sensor.alert_code;
                // Buzzer on top bit, average below
                uo_out     <= {buzzer, sensor.avg_sel[DATA_W-2:0]};
                uio_out    <= {sensor.alert_code, chan, 2'b00};   // Debug byte
            end else begin
                // Ready doubles as buzzer in camera mode
                uo_out     <= {growth.ready, growth.stage, alert_hold};
                uio_out    <= growth.maturity;
            end
        end
    end

endmodule

/* hdl/tt_um_precision_farming.sv */
`timescale 1ns/1ps

module tt_um_precision_farming import farm_pkg::*; #(
    parameter int COUNT_W          = 12,    // Pixel counter width
    parameter int MIN_FRAME_PIXELS = 100,
    parameter int MIN_GREEN_PIXELS = 10
) (
    input  logic [DATA_W-1:0] ui_in,        // Sensor reading or pixel
    output logic [DATA_W-1:0] uo_out,
    input  logic [DATA_W-1:0] uio_in,       // Control pins
    output logic [DATA_W-1:0] uio_out,
    output logic [DATA_W-1:0] uio_oe,
    input  logic              ena,
    input  logic              clk,
    input  logic              rst_n
);

    // ========================================
    // Control decode
    // ========================================
    op_mode_e       mode;
    logic           vsync;
    logic           href;
    sensor_chan_e   chan;           // uio_in[4:2] reserved

    sensor_result_t sensor_res;
    growth_result_t growth_res;

    assign mode   = op_mode_e'(uio_in[7]);
    assign vsync  = uio_in[6];
    assign href   = uio_in[5];
    assign chan   = sensor_chan_e'(uio_in[1:0]);
    assign uio_oe = '1;             // All bidirectional pins drive out

    sensor_monitor i_sensor (
        .clk     (clk),
        .rst_n   (rst_n),
        .ena     (ena),
        .mode    (mode),
        .chan    (chan),
        .reading (ui_in),
        .result  (sensor_res)
    );

    growth_classifier #(
        .COUNT_W          (COUNT_W),
        .MIN_FRAME_PIXELS (MIN_FRAME_PIXELS),
        .MIN_GREEN_PIXELS (MIN_GREEN_PIXELS)
    ) i_growth (
        .clk    (clk),
        .rst_n  (rst_n),
        .ena    (ena),
        .vsync  (vsync),
        .href   (href),
        .mode   (mode),
        .pixel  (ui_in),
        .result (growth_res)
    );

    status_combiner i_status (
        .clk     (clk),
        .rst_n   (rst_n),
        .ena     (ena),
        .mode    (mode),
        .chan    (chan),
        .sensor  (sensor_res),
        .growth  (growth_res),
        .uo_out  (uo_out),
        .uio_out (uio_out)
    );

endmodule

/* verification/farm_assertions.sv */
`timescale 1ns/1ps

module farm_assertions import farm_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              ena,
    input logic [DATA_W-1:0] uio_in,
    input logic [DATA_W-1:0] uo_out,
    input logic [DATA_W-1:0] uio_out,
    input logic [DATA_W-1:0] uio_oe,
    input growth_result_t    growth
);

    logic cam_en;   // Pins load camera status on next edge

    assign cam_en = ena && (uio_in[7] == MODE_CAMERA);

    // ========================================
    // Pin invariants
    // ========================================
    oe_all_ones: assert property (@(posedge clk) uio_oe == '1)
        else $error("uio_oe is not all ones");

    reset_clears_pins: assert property (@(posedge clk)
        !rst_n |=> (uo_out == '0) && (uio_out == '0))
        else $error("Output pins not cleared by reset");

    cam_buzzer_is_ready: assert property (@(posedge clk) disable iff (!rst_n)
        cam_en |=> (uo_out[7] == $past(growth.ready)) &&
                   (uo_out[7] == (uo_out[6:4] >= 3'd6)))
        else $error("Camera buzzer bit does not follow ready");

    cam_maturity_code: assert property (@(posedge clk) disable iff (!rst_n)
        cam_en |=> (uio_out == 8'd0)  || (uio_out == 8'd20) ||
                   (uio_out == 8'd40) || (uio_out == 8'd70) ||
                   (uio_out == 8'd90))
        else $error("Camera uio_out is not a maturity code");

endmodule

bind tt_um_precision_farming farm_assertions i_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .ena     (ena),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .growth  (growth_res)
);

/* verification/tb_farm.sv */
`timescale 1ns/1ps

module tb_farm;

    localparam int SETTLE_CYC = 12;         // Steady cycles before each check
    localparam int WATCHDOG   = 200_000;    // Whole run limit in ns

    // Window bounds in soil, temp, humid, light order
    localparam logic [7:0] WIN_MIN [4] = '{8'd140, 8'd100, 8'd120, 8'd80};
    localparam logic [7:0] WIN_MAX [4] = '{8'd210, 8'd160, 8'd190, 8'd220};

    logic        clk;
    logic        rst_n;
    logic        ena;
    logic [7:0]  ui_in;
    logic [7:0]  uio_in;
    logic [7:0]  uo_out;
    logic [7:0]  uio_out;
    logic [7:0]  uio_oe;
    logic [31:0] rng_state;
    int          err_cnt;

    tt_um_precision_farming #(
        .COUNT_W          (12),
        .MIN_FRAME_PIXELS (100),
        .MIN_GREEN_PIXELS (10)
    ) i_dut (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                  // 20 ns period

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng_state = xorshift(rng_state);
        return rng_state % n;
    endfunction

    task automatic halt_run();
        err_cnt++;
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp)
        else begin
            $display("FAIL %s: expected 0x%02h, actual 0x%02h", name, exp, act);
            halt_run();
        end
    endtask

    // Starts and ends on a falling edge so each reading is sampled once
    task automatic drive_sensor(input logic [1:0] ch, input logic [7:0] a, input logic [7:0] b);
        for (int i = 0; i < SETTLE_CYC; i++) begin
            uio_in = {6'b0, ch};            // Sensor mode
            ui_in  = i[0] ? b : a;
            @(negedge clk);
        end
    endtask

    task automatic check_sensor(input string name, input logic [1:0] ch, input logic [7:0] m,
                                input logic [3:0] alert, input logic buzz);
        check_byte({name, " uo_out"}, {buzz, m[6:0]}, uo_out);
        check_byte({name, " uio_out"}, {alert, ch, 2'b00}, uio_out);
    endtask

    function automatic logic [7:0] window_mean(input int c);
        return WIN_MIN[c] + 8'(rand_below(WIN_MAX[c] - WIN_MIN[c] + 1));
    endfunction

    // Grades in rule order where the first match wins
    function automatic logic [7:0] maturity_rule(input int nl, input int nd);
        logic [7:0] mat;
        if (nl + nd <= 10)     mat = 8'd0;
        else if (nd > 2 * nl)  mat = 8'd90;
        else if (nd > nl)      mat = 8'd70;
        else if (nl > 2 * nd)  mat = 8'd20;
        else                   mat = 8'd40;
        return mat;
    endfunction

    function automatic logic [2:0] stage_rule(input logic [7:0] mat);
        logic [2:0] stage;
        if (mat >= 8'd80)      stage = 3'd7;
        else if (mat >= 8'd60) stage = 3'd6;
        else if (mat >= 8'd40) stage = 3'd4;
        else if (mat >= 8'd20) stage = 3'd2;
        else                   stage = 3'd1;
        return stage;
    endfunction

    // RGB332 pixel of kind 0 light green, 1 deep green or 2 other
    function automatic logic [7:0] make_pixel(input int kind);
        logic [2:0] red;
        logic [2:0] green;
        red   = 3'(rand_below(2));
        green = 3'(3 + rand_below(3));
        if (kind == 1) begin
            green = 3'(6 + rand_below(2));
        end else if (kind == 2) begin
            red   = 3'(2 + rand_below(6));  // Too red for either class
            green = 3'(rand_below(8));
        end
        return {red, green, 2'(rand_below(4))};
    endfunction

    task automatic run_frame(input string name, input int nl, input int nd, input int no,
                             input logic [3:0] alert);
        int         left [3];
        int         r;
        int         kind;
        logic [7:0] mat;
        left   = '{nl, nd, no};
        uio_in = 8'hC0;                     // Camera mode with vsync
        ui_in  = '0;
        @(negedge clk);
        while (left[0] + left[1] + left[2] > 0) begin
            r    = int'(rand_below(left[0] + left[1] + left[2]));
            kind = (r < left[0]) ? 0 : (r < left[0] + left[1]) ? 1 : 2;
            left[kind]--;
            ui_in  = make_pixel(kind);
            uio_in = 8'hA0;                 // href
            @(negedge clk);
        end
        uio_in = 8'h80;                     // Idle so the frame gets graded
        ui_in  = '0;
        for (int i = 0; i < SETTLE_CYC; i++) @(negedge clk);
        mat = maturity_rule(nl, nd);
        check_byte({name, " maturity"}, mat, uio_out);
        check_byte({name, " status"}, {mat >= 8'd60, stage_rule(mat), alert}, uo_out);
    endtask

    initial begin
        #(WATCHDOG);
        $display("Watchdog expired before the run finished");
        $display("CHECKS FAILED");
        $fatal(1, "Timeout");
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        logic [7:0] m;
        logic [3:0] held;
        int         c;
        rng_state = 32'h1c280a37;
        err_cnt   = 0;
        rst_n     = 1'b0;
        ena       = 1'b1;
        ui_in     = '0;
        uio_in    = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Fill every channel since stale zero averages would alert
        for (c = 0; c < 4; c++) begin
            m = window_mean(c);
            drive_sensor(2'(c), m - 8'd2, m + 8'd2);
        end
        for (c = 0; c < 4; c++) begin
            m = window_mean(c);
            drive_sensor(2'(c), m - 8'd2, m + 8'd2);
            check_sensor($sformatf("in-window ch%0d", c), 2'(c), m, 4'h0, 1'b0);
        end

        // Out of window on one channel
        c = int'(rand_below(4));
        if (rand_below(2) == 0) m = 8'(20 + rand_below(WIN_MIN[c] - 20));
        else                    m = 8'(WIN_MAX[c] + 1 + rand_below(250 - WIN_MAX[c]));
        drive_sensor(2'(c), m - 8'd2, m + 8'd2);
        check_sensor("alert", 2'(c), m, 4'(1 << c), 1'b1);
        m = window_mean(c);
        drive_sensor(2'(c), m - 8'd2, m + 8'd2);
        check_sensor("alert cleared", 2'(c), m, 4'h0, 1'b0);

        // Stuck sensor then moving again
        c = int'(rand_below(4));
        m = window_mean(c);
        drive_sensor(2'(c), m, m);
        check_sensor("stuck", 2'(c), m, 4'h0, 1'b1);
        drive_sensor(2'(c), m - 8'd2, m + 8'd2);
        check_sensor("unstuck", 2'(c), m, 4'h0, 1'b0);

        // Soil at both rail codes which are also out of window
        drive_sensor(2'd0, 8'h00, 8'h00);
        check_sensor("extreme low", 2'd0, 8'h00, 4'h1, 1'b1);
        drive_sensor(2'd0, 8'hFF, 8'hFF);
        check_sensor("extreme high", 2'd0, 8'hFF, 4'h1, 1'b1);
        m = window_mean(0);
        drive_sensor(2'd0, m - 8'd2, m + 8'd2);
        check_sensor("soil restored", 2'd0, m, 4'h0, 1'b0);

        // Alert left raised for the camera status nibble
        c = int'(rand_below(4));
        m = 8'(WIN_MAX[c] + 1 + rand_below(250 - WIN_MAX[c]));
        drive_sensor(2'(c), m - 8'd2, m + 8'd2);
        held = 4'(1 << c);
        check_sensor("alert held", 2'(c), m, held, 1'b1);

        // Camera frames with random class mix
        for (int f = 0; f < 6; f++) begin
            int nl;
            int nd;
            int no;
            nl = int'(rand_below(60));
            nd = int'(rand_below(60));
            no = int'(rand_below(40));
            if (nl + nd + no <= 100) no = 101 - nl - nd;
            run_frame($sformatf("frame %0d", f), nl, nd, no, held);
        end
        run_frame("few green", 5, 5, 100, held);

        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
hdl/farm_pkg.sv
hdl/sensor_monitor.sv
hdl/growth_classifier.sv
hdl/status_combiner.sv
hdl/tt_um_precision_farming.sv
verification/farm_assertions.sv
verification/tb_farm.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_farm -f build.f > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_farm > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if grep -q "CHECKS FAILED" "$SIM_LOG"; then
    echo "Simulation reported a failing check"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
